//--- logic/lc3_pkg.sv
package lc3_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] word_t;        // Data word.
    typedef logic [2:0]  reg_idx_t;     // General register index.
    typedef logic [3:0]  opcode_t;      // IR[15:12].
    typedef logic [4:0]  imm5_t;        // IR[4:0], signed.
    typedef logic [2:0]  nzp_t;         // N, Z, P from msb down.

    // Operate group opcodes.
    localparam opcode_t OP_ADD = 4'b0001;
    localparam opcode_t OP_AND = 4'b0101;
    localparam opcode_t OP_NOT = 4'b1001;

    // Condition code values.
    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    // One-hot so each operation selects on a single bit.
    typedef enum logic [2:0] {
        ALU_ADD = 3'b001,
        ALU_AND = 3'b010,
        ALU_NOT = 3'b100
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles between blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic     valid;                // Legal instruction this cycle.
        alu_op_e  op;
        reg_idx_t dr;
        reg_idx_t sr1;
        reg_idx_t sr2;
        logic     use_imm;              // IR[5].
        imm5_t    imm;
    } dec_op_t;

    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
    } wr_port_t;

endpackage

//--- logic/instr_decode.sv
module instr_decode
    import lc3_pkg::*;
(
    input  logic    instr_valid,
    input  word_t   instr,
    output dec_op_t dec
);

    opcode_t opcode;
    logic    legal;                     // Opcode is in the operate group.
    alu_op_e op;

    assign opcode = opcode_t'(instr[15:12]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode to ALU operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        legal = 1'b1;
        op    = ALU_ADD;
        case (opcode)
            OP_ADD :
            begin
                op = ALU_ADD;
            end
            OP_AND :
            begin
                op = ALU_AND;
            end
            OP_NOT :
            begin
                op = ALU_NOT;
            end
            default :
            begin
                legal = 1'b0;           // Anything else is dropped.
                op    = ALU_ADD;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        dec.valid   = instr_valid & legal;
        dec.op      = op;
        dec.dr      = reg_idx_t'(instr[11:9]);
        dec.sr1     = reg_idx_t'(instr[8:6]);
        dec.sr2     = reg_idx_t'(instr[2:0]);   // Meaningless in the imm form.
        dec.use_imm = instr[5];
        dec.imm     = imm5_t'(instr[4:0]);
    end

endmodule

//--- logic/gpr_cell.sv
module gpr_cell
    import lc3_pkg::*;
#(
    parameter int INDEX = 0
)(
    input  logic     Clk,
    input  logic     reset,
    input  wr_port_t wr,
    input  reg_idx_t sr1,
    input  reg_idx_t sr2,
    output word_t    sr1_part,
    output word_t    sr2_part
);

    word_t value;

    always_ff @(posedge Clk)
    begin
        if (reset)
            value <= '0;
        else if (wr.en && (wr.addr == reg_idx_t'(INDEX)))
            value <= wr.data;
    end

    // Zero unless selected, so the file can OR all cells together.
    assign sr1_part = (sr1 == reg_idx_t'(INDEX)) ? value : '0;
    assign sr2_part = (sr2 == reg_idx_t'(INDEX)) ? value : '0;

endmodule

//--- logic/reg_file.sv
module reg_file
    import lc3_pkg::*;
#(
    parameter int NUM_REGS = 8
)(
    input  logic     Clk,
    input  logic     reset,
    input  wr_port_t wr,
    input  dec_op_t  dec,
    output word_t    sr1_data,
    output word_t    sr2_data
);

    word_t sr1_parts [NUM_REGS];
    word_t sr2_parts [NUM_REGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register cells
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    genvar i;
    generate
        for (i = 0; i < NUM_REGS; i++)
        begin : g_reg
            gpr_cell #(
                .INDEX    (i)
            ) u_cell (
                .Clk      (Clk),
                .reset    (reset),
                .wr       (wr),
                .sr1      (dec.sr1),
                .sr2      (dec.sr2),
                .sr1_part (sr1_parts[i]),
                .sr2_part (sr2_parts[i])
            );
        end
    endgenerate

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // At most one cell matches each address; an index past NUM_REGS reads 0.
    always_comb
    begin
        sr1_data = '0;
        sr2_data = '0;
        for (int k = 0; k < NUM_REGS; k++)
        begin
            sr1_data = sr1_data | sr1_parts[k];
            sr2_data = sr2_data | sr2_parts[k];
        end
    end

endmodule

//--- logic/alu.sv
module alu
    import lc3_pkg::*;
(
    input  dec_op_t dec,
    input  word_t   sr1_data,
    input  word_t   sr2_data,
    output word_t   alu_result
);

    word_t imm_ext;
    word_t operand_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Second operand
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_ext   = {{11{dec.imm[4]}}, dec.imm};     // Sign-extend imm5.
    assign operand_b = dec.use_imm ? imm_ext : sr2_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operate group
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        case (dec.op)
            ALU_ADD :
            begin
                alu_result = sr1_data + operand_b;  // Wraps at 16 bits.
            end
            ALU_AND :
            begin
                alu_result = sr1_data & operand_b;
            end
            ALU_NOT :
            begin
                alu_result = ~sr1_data;
            end
            default :
            begin
                alu_result = '0;
            end
        endcase
    end

endmodule

//--- logic/exec_writeback.sv
module exec_writeback
    import lc3_pkg::*;
(
    input  logic     Clk,
    input  logic     reset,
    input  dec_op_t  dec,
    input  word_t    alu_result,
    input  logic     load_valid,
    input  reg_idx_t load_dr,
    input  word_t    load_data,
    output wr_port_t wr,
    output logic     result_valid,
    output word_t    result,
    output nzp_t     nzp
);

    nzp_t nzp_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        if (dec.valid)
        begin
            wr.en   = 1'b1;             // Instruction wins, load is lost.
            wr.addr = dec.dr;
            wr.data = alu_result;
        end
        else
        begin
            wr.en   = load_valid;
            wr.addr = load_dr;
            wr.data = load_data;
        end
    end

    // Condition codes from the unregistered result.
    always_comb
    begin
        if (alu_result[15])
            nzp_next = NZP_N;
        else if (alu_result == '0)
            nzp_next = NZP_Z;
        else
            nzp_next = NZP_P;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            result       <= '0;
            nzp          <= NZP_Z;
        end
        else
        begin
            result_valid <= dec.valid;  // One pulse per instruction.
            if (dec.valid)
            begin
                result <= alu_result;
                nzp    <= nzp_next;
            end
        end
    end

endmodule

//--- logic/lc3_exec_top.sv
module lc3_exec_top
    import lc3_pkg::*;
#(
    parameter int NUM_REGS = 8
)(
    input  logic     Clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  word_t    instr,
    input  logic     load_valid,
    input  reg_idx_t load_dr,
    input  word_t    load_data,
    output logic     result_valid,
    output word_t    result,
    output nzp_t     nzp
);

    dec_op_t  dec;
    wr_port_t wr;
    word_t    sr1_data;
    word_t    sr2_data;
    word_t    alu_result;

    instr_decode u_decode (
        .instr_valid  (instr_valid),
        .instr        (instr),
        .dec          (dec)
    );

    reg_file #(
        .NUM_REGS     (NUM_REGS)
    ) u_reg_file (
        .Clk          (Clk),
        .reset        (reset),
        .wr           (wr),
        .dec          (dec),
        .sr1_data     (sr1_data),
        .sr2_data     (sr2_data)
    );

    alu u_alu (
        .dec          (dec),
        .sr1_data     (sr1_data),
        .sr2_data     (sr2_data),
        .alu_result   (alu_result)
    );

    // Closes the loop back into the register file.
    exec_writeback u_writeback (
        .Clk          (Clk),
        .reset        (reset),
        .dec          (dec),
        .alu_result   (alu_result),
        .load_valid   (load_valid),
        .load_dr      (load_dr),
        .load_data    (load_data),
        .wr           (wr),
        .result_valid (result_valid),
        .result       (result),
        .nzp          (nzp)
    );

endmodule

//--- verif/lc3_exec_assertions.sv
module lc3_exec_assertions
    import lc3_pkg::*;
(
    input logic     Clk,
    input logic     reset,
    input logic     instr_valid,
    input word_t    instr,
    input logic     load_valid,
    input reg_idx_t load_dr,
    input word_t    load_data,
    input logic     result_valid,
    input word_t    result,
    input nzp_t     nzp
);

    word_t       shadow [8];            // Expected register contents.
    logic        legal;
    word_t       exp_now;
    logic        pend_q;                // Legal strobe seen last edge.
    logic        seen_q;
    word_t       exp_q;
    nzp_t        exp_nzp_q;
    int unsigned fail_count = 0;

    // Operate-group result from the LC-3 definitions.
    function automatic word_t operate(input word_t ir, input word_t a, input word_t b);
        word_t opnd;
        opnd = ir[5] ? {{11{ir[4]}}, ir[4:0]} : b;
        case (ir[15:12])
            OP_ADD : return a + opnd;
            OP_AND : return a & opnd;
            default : return ~a;
        endcase
    endfunction

    function automatic nzp_t classify(input word_t v);
        if (v[15])
            return NZP_N;
        return (v == 16'h0000) ? NZP_Z : NZP_P;
    endfunction

    assign legal   = (instr[15:12] == OP_ADD) || (instr[15:12] == OP_AND)
                     || (instr[15:12] == OP_NOT);
    assign exp_now = operate(instr, shadow[instr[8:6]], shadow[instr[2:0]]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shadow model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            for (int k = 0; k < 8; k++)
                shadow[k] <= '0;
            pend_q    <= 1'b0;
            seen_q    <= 1'b0;
            exp_q     <= '0;
            exp_nzp_q <= NZP_Z;
        end
        else
        begin
            pend_q <= instr_valid && legal;
            if (instr_valid && legal)
            begin
                shadow[instr[11:9]] <= exp_now;     // A load in this cycle is lost.
                exp_q               <= exp_now;
                exp_nzp_q           <= classify(exp_now);
                seen_q              <= 1'b1;
            end
            else if (load_valid)
                shadow[load_dr] <= load_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_state : assert property (@(posedge Clk) disable iff (reset)
        !seen_q |-> (!result_valid && nzp == NZP_Z && result == 16'h0000))
    else
    begin
        $error("CHECK FAILED at %0t: result_valid/nzp/result got %b/%b/%h, expected 0/010/0000",
               $time, $sampled(result_valid), $sampled(nzp), $sampled(result));
        fail_count++;
    end

    a_valid_timing : assert property (@(posedge Clk) disable iff (reset)
        result_valid == pend_q)
    else
    begin
        $error("CHECK FAILED at %0t: result_valid got %b, expected %b",
               $time, $sampled(result_valid), $sampled(pend_q));
        fail_count++;
    end

    a_result_value : assert property (@(posedge Clk) disable iff (reset)
        result_valid |-> (result == exp_q))
    else
    begin
        $error("CHECK FAILED at %0t: result got %h, expected %h",
               $time, $sampled(result), $sampled(exp_q));
        fail_count++;
    end

    a_nzp_value : assert property (@(posedge Clk) disable iff (reset)
        nzp == exp_nzp_q)
    else
    begin
        $error("CHECK FAILED at %0t: nzp got %b, expected %b",
               $time, $sampled(nzp), $sampled(exp_nzp_q));
        fail_count++;
    end

endmodule

bind lc3_exec_top lc3_exec_assertions u_checks (
    .Clk          (Clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .load_valid   (load_valid),
    .load_dr      (load_dr),
    .load_data    (load_data),
    .result_valid (result_valid),
    .result       (result),
    .nzp          (nzp)
);

//--- verif/tb_lc3_exec.sv
module tb_lc3_exec
    import lc3_pkg::*;
;

    localparam int RESULT_TIMEOUT = 20;

    logic     Clk;
    logic     reset;
    logic     instr_valid;
    word_t    instr;
    logic     load_valid;
    reg_idx_t load_dr;
    word_t    load_data;
    logic     result_valid;
    word_t    result;
    nzp_t     nzp;

    int test_start;
    int test_timeouts;
    int tests_run;
    int tests_failed;
    int total_errors;

    lc3_exec_top #(
        .NUM_REGS     (8)
    ) dut0 (
        .Clk          (Clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .load_valid   (load_valid),
        .load_dr      (load_dr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result       (result),
        .nzp          (nzp)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t make_op(input opcode_t opc, input reg_idx_t dr,
                                      input reg_idx_t sr1, input logic imm_form,
                                      input logic [4:0] low5);
        return {opc, dr, sr1, imm_form, low5};
    endfunction

    task automatic drive_instr(input word_t w);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge Clk);
        instr_valid = 1'b0;
    endtask

    task automatic drive_load(input reg_idx_t dr, input word_t data);
        load_valid = 1'b1;
        load_dr    = dr;
        load_data  = data;
        @(negedge Clk);
        load_valid = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!result_valid && n < RESULT_TIMEOUT)
        begin
            @(negedge Clk);
            n++;
        end
        if (!result_valid)
        begin
            $display("ERROR at %0t: result_valid did not rise within %0d cycles",
                     $time, RESULT_TIMEOUT);
            test_timeouts++;
        end
    endtask

    // ADD r, r, #0 on every register, back to back.
    task automatic read_all_regs();
        for (int r = 0; r < 8; r++)
            drive_instr(make_op(OP_ADD, reg_idx_t'(r), reg_idx_t'(r), 1'b1, 5'd0));
        wait_result();
    endtask

    task automatic begin_test();
        test_start    = int'(dut0.u_checks.fail_count);
        test_timeouts = 0;
    endtask

    task automatic end_test(input string name);
        int errs;
        repeat (2) @(negedge Clk);      // Let the last result reach the checker.
        errs = int'(dut0.u_checks.fail_count) - test_start + test_timeouts;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        total_errors += errs;
        $display("test %-16s finished, %0d errors", name, errs);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_register_arith();
        int       sel;
        reg_idx_t dr;
        reg_idx_t sr1;
        logic     imm_form;
        opcode_t  opc;
        drive_instr(make_op(OP_ADD, 3'd2, 3'd5, 1'b1, 5'b11000));     // R5 - 8.
        for (int i = 0; i < 40; i++)
        begin
            sel      = int'($urandom_range(2, 0));
            dr       = reg_idx_t'($urandom_range(7, 0));
            sr1      = reg_idx_t'($urandom_range(7, 0));
            imm_form = 1'($urandom_range(1, 0));
            opc      = (sel == 0) ? OP_ADD : ((sel == 1) ? OP_AND : OP_NOT);
            if (imm_form)
                drive_instr(make_op(opc, dr, sr1, 1'b1, 5'($urandom)));
            else
                drive_instr(make_op(opc, dr, sr1, 1'b0, {2'b00, 3'($urandom)}));
        end
        wait_result();
    endtask

    task automatic test_condition_codes();
        drive_load(3'd1, 16'h8000);
        drive_instr(make_op(OP_ADD, 3'd2, 3'd1, 1'b1, 5'd0));          // Negative.
        wait_result();
        drive_load(3'd3, 16'h0005);
        drive_instr(make_op(OP_AND, 3'd4, 3'd1, 1'b1, 5'd0));          // Zero.
        wait_result();
        drive_load(3'd6, 16'h7fff);
        drive_instr(make_op(OP_ADD, 3'd5, 3'd3, 1'b1, 5'd1));          // Positive.
        wait_result();
        drive_instr(make_op(OP_NOT, 3'd7, 3'd4, 1'b1, 5'b11111));
        wait_result();
    endtask

    task automatic test_priority_illegal();
        // Instruction and load in the same cycle.
        instr_valid = 1'b1;
        instr       = make_op(OP_ADD, 3'd1, 3'd1, 1'b1, 5'd1);
        load_valid  = 1'b1;
        load_dr     = 3'd1;
        load_data   = 16'hdead;
        @(negedge Clk);
        instr       = make_op(OP_ADD, 3'd3, 3'd3, 1'b1, 5'd2);
        load_dr     = 3'd2;
        load_data   = 16'hbeef;
        @(negedge Clk);
        instr_valid = 1'b0;
        load_valid  = 1'b0;
        wait_result();
        drive_instr({4'b0000, 12'($urandom)});
        drive_instr({4'b0110, 12'($urandom)});
        drive_instr({4'b1101, 12'($urandom)});
        drive_instr({4'b1111, 12'($urandom)});
        instr = make_op(OP_ADD, 3'd0, 3'd0, 1'b1, 5'd7);    // Not strobed.
        repeat (2) @(negedge Clk);
        read_all_regs();
    endtask

    initial
    begin
        void'($urandom(15243));
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        load_valid   = 1'b0;
        load_dr      = '0;
        load_data    = '0;
        repeat (4) @(negedge Clk);
        reset = 1'b0;

        begin_test();
        repeat (3) @(negedge Clk);
        drive_instr(make_op(OP_ADD, 3'd0, 3'd0, 1'b1, 5'd0));          // First instruction.
        wait_result();
        end_test("reset_state");

        begin_test();
        for (int r = 0; r < 8; r++)
            drive_load(reg_idx_t'(r), word_t'($urandom));
        read_all_regs();
        end_test("load_readback");

        begin_test();
        test_register_arith();
        end_test("register_arith");

        begin_test();
        test_condition_codes();
        end_test("condition_codes");

        begin_test();
        test_priority_illegal();
        end_test("priority_illegal");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- src.f
logic/lc3_pkg.sv
logic/instr_decode.sv
logic/gpr_cell.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_writeback.sv
logic/lc3_exec_top.sv
verif/lc3_exec_assertions.sv
verif/tb_lc3_exec.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
RUN_FLAGS = +verilator+error+limit+100
TOP       = tb_lc3_exec
FILELIST  = src.f
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) > $(LOG) 2>&1 \
		|| echo "RESULT: FAIL" >> $(LOG)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) >> $(LOG) 2>&1 || echo "RESULT: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
